// ==== filelist.f ====
+incdir+include
logic/gpio_pkg.sv
logic/gpio_sync.sv
logic/gpio_debounce.sv
logic/gpio_regs.sv
logic/gpio_top.sv
sim/gpio_tb.sv

// ==== Bender.yml ====
package:
  name: gpio_periph

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - logic/gpio_pkg.sv
      - logic/gpio_sync.sv
      - logic/gpio_debounce.sv
      - logic/gpio_regs.sv
      - logic/gpio_top.sv
      - target: simulation
        files:
          - sim/gpio_tb.sv

// ==== sim/gpio_tb.sv ====
/*
 * Directed testbench for the GPIO peripheral
 * Clock, reset, watchdog, Wishbone master tasks,
 * compare tasks and tests
 */
`include "gpio_consts.svh"

module gpio_tb;

   localparam int PERIOD = 40;
   // Cycle budget of reset and each test in run order
   localparam int BUDGET = 10 + 20 + 100 + 150 + 60 + 120 + 80;

   logic               clk;
   logic               rst_n;
   gpio_pkg::wb_req_t  wb_req;
   gpio_pkg::wb_rsp_t  wb_rsp;
   gpio_pkg::io_word_t sw;
   gpio_pkg::io_word_t led;
   logic               irq;

   // Debounced switch word the DUT should settle to
   gpio_pkg::io_word_t sw_model;
   // Interrupt enable mask written by the irq test
   gpio_pkg::io_word_t irq_en;
   int unsigned        cyc_cnt = 0;
   int                 errors;
   int                 errors_at_start;
   int                 tests_run;
   int                 tests_failed;
   string              test_name;

   gpio_top uut (
      .clk     (clk),
      .i_rst_n (rst_n),
      .i_wb    (wb_req),
      .o_wb    (wb_rsp),
      .i_sw    (sw),
      .o_led   (led),
      .o_irq   (irq)
   );

   //**************************************************
   // Clock, cycle count, watchdog
   //**************************************************
   initial clk = 1'b0;
   always #(PERIOD / 2) clk = ~clk;

   always @(posedge clk) cyc_cnt <= cyc_cnt + 1;

   initial begin
      #(BUDGET * 2 * PERIOD);
      $display("Watchdog expired before the tests finished");
      $display("STATUS: FAIL");
      $finish;
   end

   //**************************************************
   // Bus master
   //**************************************************
   // Inputs change 5 units after the edge
   task automatic next_cycle();
      @(posedge clk);
      #5;
   endtask

   task automatic wb_access(input logic we, input gpio_pkg::reg_addr_t adr,
                            input logic [`WB_DW-1:0] wdat,
                            output gpio_pkg::wb_rsp_t rsp);
      int waited;
      waited = 0;
      wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat};
      // Request held until ack
      do begin
         next_cycle();
         waited++;
      end while (!wb_rsp.ack && waited < 4);
      rsp = wb_rsp;
      if (!wb_rsp.ack) begin
         $display("No acknowledge from the DUT within 4 cycles for %s", adr.name());
         errors++;
      end
      wb_req = '0;
      // One idle cycle before the next request
      next_cycle();
      // Ack lasts a single cycle
      if (wb_rsp.ack) begin
         $display("Acknowledge for %s stayed high for more than one cycle", adr.name());
         errors++;
      end
   endtask

   task automatic wb_write(input gpio_pkg::reg_addr_t adr, input logic [`WB_DW-1:0] wdat);
      gpio_pkg::wb_rsp_t rsp;
      wb_access(1'b1, adr, wdat, rsp);
   endtask

   task automatic wb_read(input gpio_pkg::reg_addr_t adr, output gpio_pkg::wb_rsp_t rsp);
      wb_access(1'b0, adr, '0, rsp);
   endtask

   //**************************************************
   // Compare tasks
   //**************************************************
   task automatic check_word(input string name, input logic [`WB_DW-1:0] exp,
                             input gpio_pkg::wb_rsp_t act);
      if (act.dat !== exp) begin
         $display("Fail %s expected %h got %h", name, exp, act.dat);
         errors++;
      end
   endtask

   task automatic check_io(input string name, input gpio_pkg::io_word_t exp,
                           input gpio_pkg::io_word_t act);
      if (act !== exp) begin
         $display("Fail %s expected %h got %h", name, exp, act);
         errors++;
      end
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         $display("Fail %s expected %h got %h", name, exp, act);
         errors++;
      end
   endtask

   task automatic read_check(input gpio_pkg::reg_addr_t adr, input logic [`WB_DW-1:0] exp);
      gpio_pkg::wb_rsp_t rsp;
      wb_read(adr, rsp);
      check_word($sformatf("o_wb.dat[%s]", adr.name()), exp, rsp);
   endtask

   //**************************************************
   // Helpers
   //**************************************************
   function automatic gpio_pkg::io_word_t lowest_bit(input gpio_pkg::io_word_t w);
      return w & (~w + 1'b1);
   endfunction

   // Hold a new switch word and poll REG_SW for up to 20 cycles
   task automatic set_switches(input gpio_pkg::io_word_t v);
      gpio_pkg::wb_rsp_t rsp;
      int unsigned       t0;
      sw       = v;
      sw_model = v;
      t0       = cyc_cnt;
      do begin
         wb_read(gpio_pkg::ADR_SW, rsp);
      end while (rsp.dat !== `WB_DW'(v) && (cyc_cnt - t0) < 20);
      check_word("o_wb.dat[ADR_SW]", `WB_DW'(v), rsp);
   endtask

   task automatic start_test(input string name);
      test_name       = name;
      errors_at_start = errors;
   endtask

   task automatic finish_test();
      tests_run++;
      if (errors == errors_at_start) begin
         $display("Test %-8s passed", test_name);
      end else begin
         tests_failed++;
         $display("Test %-8s failed with %0d errors", test_name, errors - errors_at_start);
      end
   endtask

   //**************************************************
   // Tests
   //**************************************************
   task automatic test_reset();
      start_test("reset");
      check_io("o_led", '0, led);
      check_bit("o_irq", 1'b0, irq);
      for (int a = 0; a < 4; a++) begin
         read_check(gpio_pkg::reg_addr_t'(a), '0);
      end
      finish_test();
   endtask

   task automatic test_led();
      logic [`WB_DW-1:0] wdat;
      start_test("led");
      repeat (8) begin
         // Upper bus bits must be dropped
         wdat = $urandom;
         wb_write(gpio_pkg::ADR_LED, wdat);
         check_io("o_led", wdat[`GPIO_W-1:0], led);
         read_check(gpio_pkg::ADR_LED, wdat[`GPIO_W-1:0]);
      end
      // Switch word is read-only
      wb_write(gpio_pkg::ADR_SW, $urandom);
      read_check(gpio_pkg::ADR_SW, sw_model);
      finish_test();
   endtask

   task automatic test_switch();
      start_test("switch");
      repeat (4) begin
         set_switches(gpio_pkg::io_word_t'($urandom));
      end
      finish_test();
   endtask

   task automatic test_glitch();
      gpio_pkg::io_word_t pulse;
      start_test("glitch");
      wb_write(gpio_pkg::ADR_IRQ_STAT, '1);
      read_check(gpio_pkg::ADR_IRQ_STAT, '0);
      pulse = '0;
      pulse[$urandom % `GPIO_W] = 1'b1;
      // Pulse of half the debounce length is filtered out
      sw = sw_model ^ pulse;
      repeat (`DB_CYCLES / 2) next_cycle();
      sw = sw_model;
      repeat (8) read_check(gpio_pkg::ADR_SW, sw_model);
      read_check(gpio_pkg::ADR_IRQ_STAT, '0);
      finish_test();
   endtask

   task automatic test_irq();
      gpio_pkg::io_word_t chg;
      start_test("irq");
      // Bit 0 disabled and bit 1 enabled
      irq_en = (gpio_pkg::io_word_t'($urandom) & 16'hfffe) | 16'h0002;
      wb_write(gpio_pkg::ADR_IRQ_EN, irq_en);
      read_check(gpio_pkg::ADR_IRQ_EN, irq_en);
      wb_write(gpio_pkg::ADR_IRQ_STAT, '1);
      check_bit("o_irq", 1'b0, irq);
      chg = (gpio_pkg::io_word_t'($urandom) & irq_en) | lowest_bit(irq_en);
      set_switches(sw_model ^ chg);
      read_check(gpio_pkg::ADR_IRQ_STAT, chg);
      check_bit("o_irq", 1'b1, irq);
      wb_write(gpio_pkg::ADR_IRQ_STAT, '1);
      // Disabled bits only
      chg = (gpio_pkg::io_word_t'($urandom) & ~irq_en) | 16'h0001;
      set_switches(sw_model ^ chg);
      read_check(gpio_pkg::ADR_IRQ_STAT, chg);
      check_bit("o_irq", 1'b0, irq);
      wb_write(gpio_pkg::ADR_IRQ_STAT, '1);
      finish_test();
   endtask

   task automatic test_clear();
      gpio_pkg::io_word_t stat;
      gpio_pkg::io_word_t keep;
      start_test("clear");
      stat = irq_en | 16'h0001;
      keep = lowest_bit(irq_en);
      set_switches(sw_model ^ stat);
      read_check(gpio_pkg::ADR_IRQ_STAT, stat);
      check_bit("o_irq", 1'b1, irq);
      // One enabled bit left pending
      wb_write(gpio_pkg::ADR_IRQ_STAT, stat & ~(keep | 16'h0001));
      read_check(gpio_pkg::ADR_IRQ_STAT, keep | 16'h0001);
      check_bit("o_irq", 1'b1, irq);
      // Only the disabled bit left
      wb_write(gpio_pkg::ADR_IRQ_STAT, keep);
      read_check(gpio_pkg::ADR_IRQ_STAT, 16'h0001);
      check_bit("o_irq", 1'b0, irq);
      wb_write(gpio_pkg::ADR_IRQ_STAT, 16'h0001);
      read_check(gpio_pkg::ADR_IRQ_STAT, '0);
      finish_test();
   endtask

   //**************************************************
   // Run
   //**************************************************
   initial begin
      void'($urandom(50368));
      rst_n        = 1'b0;
      wb_req       = '0;
      sw           = '0;
      sw_model     = '0;
      irq_en       = '0;
      errors       = 0;
      tests_run    = 0;
      tests_failed = 0;
      repeat (10) @(posedge clk);
      #5;
      rst_n = 1'b1;
      next_cycle();
      test_reset();
      test_led();
      test_switch();
      test_glitch();
      test_irq();
      test_clear();
      $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
      if (errors == 0) begin
         $display("STATUS: PASS");
      end else begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

endmodule

// ==== logic/gpio_top.sv ====
/*
 * Switch pipeline of synchronizer, debouncer and
 * Wishbone register stage, mapped to ports
 */

module gpio_top (
   input  logic               clk,
   input  logic               i_rst_n,
   input  gpio_pkg::wb_req_t  i_wb,
   output gpio_pkg::wb_rsp_t  o_wb,
   input  gpio_pkg::io_word_t i_sw,
   output gpio_pkg::io_word_t o_led,
   output logic               o_irq
);

   //************************************************
   // Stage links
   //************************************************
   // Synchronizer to debouncer
   gpio_pkg::io_word_t sw_sync;
   // Debouncer to register stage
   gpio_pkg::io_word_t sw_db;

   // Clock-domain boundary for the raw switches
   gpio_sync u_sync (
      .clk     (clk),
      .i_rst_n (i_rst_n),
      .i_sw    (i_sw),
      .o_sw    (sw_sync)
   );

   // Contact bounce filter
   gpio_debounce u_debounce (
      .clk     (clk),
      .i_rst_n (i_rst_n),
      .i_sw    (sw_sync),
      .o_sw    (sw_db)
   );

   // Bus-visible registers and interrupt
   gpio_regs u_regs (
      .clk     (clk),
      .i_rst_n (i_rst_n),
      .i_wb    (i_wb),
      .o_wb    (o_wb),
      .i_sw    (sw_db),
      .o_led   (o_led),
      .o_irq   (o_irq)
   );

endmodule

// ==== logic/gpio_regs.sv ====
/*
 * Wishbone slave with LED, switch, interrupt status
 * and interrupt enable registers, interrupt output
 */
`include "gpio_consts.svh"

module gpio_regs (
   input  logic               clk,
   input  logic               i_rst_n,
   input  gpio_pkg::wb_req_t  i_wb,
   output gpio_pkg::wb_rsp_t  o_wb,
   input  gpio_pkg::io_word_t i_sw,
   output gpio_pkg::io_word_t o_led,
   output logic               o_irq
);

   //************************************************
   // Declarations
   //************************************************
   logic               ack_q;
   logic               req_new;
   logic               wr_en;
   logic [`WB_DW-1:0]  rdata_d;
   logic [`WB_DW-1:0]  rdata_q;
   gpio_pkg::io_word_t wr_word;
   gpio_pkg::io_word_t led_q;
   gpio_pkg::io_word_t sw_prev_q;
   gpio_pkg::io_word_t stat_q;
   gpio_pkg::io_word_t en_q;
   gpio_pkg::io_word_t sw_chg;
   gpio_pkg::io_word_t stat_clr;

   //************************************************
   // Bus handshake
   //************************************************
   // New request gated by last ack so a held strobe acks once
   assign req_new = i_wb.cyc & i_wb.stb & ~ack_q;
   assign wr_en   = req_new & i_wb.we;
   // Only the low bits carry register data
   assign wr_word = i_wb.dat[`GPIO_W-1:0];

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= req_new;
      end
   end

   //************************************************
   // Register file
   //************************************************
   // Bits that moved since last cycle
   assign sw_chg = i_sw ^ sw_prev_q;

   // Write-one-to-clear on the status word
   assign stat_clr = (wr_en && (i_wb.adr == gpio_pkg::ADR_IRQ_STAT)) ? wr_word : '0;

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         led_q     <= '0;
         sw_prev_q <= '0;
         stat_q    <= '0;
         en_q      <= '0;
      end else begin
         sw_prev_q <= i_sw;
         // New change wins over a clear of the same bit
         stat_q    <= (stat_q & ~stat_clr) | sw_chg;
         if (wr_en) begin
            case (i_wb.adr)
               gpio_pkg::ADR_LED:    led_q <= wr_word;
               gpio_pkg::ADR_IRQ_EN: en_q  <= wr_word;
               // Switch word is read-only and status is handled above
               default: ;
            endcase
         end
      end
   end

   //************************************************
   // Read path
   //************************************************
   always_comb begin
      rdata_d = '0;
      case (i_wb.adr)
         gpio_pkg::ADR_LED:      rdata_d = `WB_DW'(led_q);
         gpio_pkg::ADR_SW:       rdata_d = `WB_DW'(i_sw);
         gpio_pkg::ADR_IRQ_STAT: rdata_d = `WB_DW'(stat_q);
         gpio_pkg::ADR_IRQ_EN:   rdata_d = `WB_DW'(en_q);
         default:                rdata_d = '0;
      endcase
   end

   // Captured with the request and presented during ack
   always_ff @(posedge clk) begin
      if (req_new) begin
         rdata_q <= rdata_d;
      end
   end

   //************************************************
   // Outputs
   //************************************************
   assign o_wb  = '{ack: ack_q, dat: rdata_q};
   assign o_led = led_q;
   // Any enabled pending bit
   assign o_irq = |(stat_q & en_q);

   //************************************************
   // Checks
   //************************************************
   // One ack per request and never back to back
   a_ack_single: assert property (
      @(posedge clk) disable iff (!i_rst_n)
      ack_q |=> !ack_q
   );

   // Ack answers a strobe seen the cycle before
   a_ack_after_req: assert property (
      @(posedge clk) disable iff (!i_rst_n)
      ack_q |-> $past(i_wb.cyc && i_wb.stb)
   );

endmodule

// ==== logic/gpio_debounce.sv ====
/*
 * Per-bit stability counters, debounced switch word,
 * check on when a debounced bit may flip
 */
`include "gpio_consts.svh"

module gpio_debounce (
   input  logic               clk,
   input  logic               i_rst_n,
   input  gpio_pkg::io_word_t i_sw,
   output gpio_pkg::io_word_t o_sw
);

   // Counter must be able to hold DB_CYCLES itself
   localparam int CNT_W = $clog2(`DB_CYCLES + 1);

   //************************************************
   // State
   //************************************************
   // Stored debounced level
   gpio_pkg::io_word_t db_q;
   // Cycles the input has differed for each bit
   logic [CNT_W-1:0]   cnt_q [`GPIO_W];

   //************************************************
   // Counters and debounced bits
   //************************************************
   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         db_q <= '0;
         for (int b = 0; b < `GPIO_W; b++) begin
            cnt_q[b] <= '0;
         end
      end else begin
         for (int b = 0; b < `GPIO_W; b++) begin
            if (i_sw[b] == db_q[b]) begin
               // Input agrees again so the glitch is forgotten
               cnt_q[b] <= '0;
            end else if (cnt_q[b] == CNT_W'(`DB_CYCLES)) begin
               // Take the new level once held long enough
               db_q[b]  <= i_sw[b];
               cnt_q[b] <= '0;
            end else begin
               cnt_q[b] <= cnt_q[b] + 1'b1;
            end
         end
      end
   end

   assign o_sw = db_q;

   //************************************************
   // Checks
   //************************************************
   for (genvar g = 0; g < `GPIO_W; g++) begin : g_db_chk
      // A flip needs a full stability run beforehand
      a_flip_after_run: assert property (
         @(posedge clk) disable iff (!i_rst_n)
         $changed(db_q[g]) |-> ($past(cnt_q[g]) == CNT_W'(`DB_CYCLES))
      );
   end

endmodule

// ==== logic/gpio_sync.sv ====
/*
 * Multi-flop synchronizer for the raw slider switches
 */
`include "gpio_consts.svh"

module gpio_sync (
   input  logic               clk,
   input  logic               i_rst_n,
   input  gpio_pkg::io_word_t i_sw,
   output gpio_pkg::io_word_t o_sw
);

   //************************************************
   // Flop chain with one word per stage
   //************************************************
   gpio_pkg::io_word_t sync_q [`SYNC_STAGES];

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         for (int s = 0; s < `SYNC_STAGES; s++) begin
            sync_q[s] <= '0;
         end
      end else begin
         // First stage may go metastable
         sync_q[0] <= i_sw;
         // Remaining stages settle it
         for (int s = 1; s < `SYNC_STAGES; s++) begin
            sync_q[s] <= sync_q[s-1];
         end
      end
   end

   // Last stage is safe to use in this domain
   assign o_sw = sync_q[`SYNC_STAGES-1];

endmodule

// ==== logic/gpio_pkg.sv ====
/*
 * GPIO peripheral types
 * Switch/LED word, register address enumeration,
 * packed Wishbone request and response
 */
`include "gpio_consts.svh"

package gpio_pkg;

   // One word of switch or LED bits
   typedef logic [`GPIO_W-1:0] io_word_t;

   // Register select by word address on the bus
   typedef enum logic [1:0] {
      ADR_LED      = `REG_LED,
      ADR_SW       = `REG_SW,
      ADR_IRQ_STAT = `REG_IRQ_STAT,
      ADR_IRQ_EN   = `REG_IRQ_EN
   } reg_addr_t;

   // Master to slave request of 37 bits
   typedef struct packed {
      logic              cyc;
      logic              stb;
      logic              we;
      reg_addr_t         adr;
      logic [`WB_DW-1:0] dat;
   } wb_req_t;

   // Slave to master response of 33 bits
   typedef struct packed {
      logic              ack;
      logic [`WB_DW-1:0] dat;
   } wb_rsp_t;

endpackage

// ==== include/gpio_consts.svh ====
/*
 * GPIO peripheral constants
 * Widths of the switch/LED word and the Wishbone data bus,
 * register word offsets, debounce length, synchronizer depth
 */
`ifndef GPIO_CONSTS_SVH
`define GPIO_CONSTS_SVH

// Number of slider switches and LEDs
`define GPIO_W 16

// Wishbone data bus width
`define WB_DW 32

// Register word offsets within the peripheral
`define REG_LED      2'd0
`define REG_SW       2'd1
`define REG_IRQ_STAT 2'd2
`define REG_IRQ_EN   2'd3

// Cycles a new level must hold before the debounced bit follows
`define DB_CYCLES   8
// Flops in the switch synchronizer
`define SYNC_STAGES 2

`endif
